//--- verilog/i3c_target_pkg.sv
// Shared types, protocol constants and CCC codes, imported by every module of the I3C target
`default_nettype none

package i3c_target_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;
  typedef logic [15:0] count_t;
  typedef logic [7:0] rst_act_t;

  // Single-cycle bus flags plus the synchronized SDA level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  typedef struct packed {
    addr_t sta_addr;
    logic  sta_valid;
    addr_t dyn_addr;
    logic  dyn_valid;
  } addr_cfg_t;

  typedef struct packed {
    logic  is_code;
    byte_t value;
  } ccc_beat_t;

  typedef struct packed {
    logic   err;
    count_t byte_count;
  } rx_desc_t;

  typedef struct packed {
    logic ibi;
    logic crr;
    logic hj;
  } event_en_t;

  typedef enum logic [2:0] {
    Idle,
    Address,
    AckAddress,
    CccCode,
    CccData,
    WriteData,
    Ignore
  } fsm_state_e;

  localparam addr_t BroadcastAddr = 7'h7E;

  // Broadcast CCC codes
  localparam byte_t CccEnec   = 8'h00;
  localparam byte_t CccDisec  = 8'h01;
  localparam byte_t CccSetmwl = 8'h09;
  localparam byte_t CccRstact = 8'h2A;

  localparam rst_act_t RstActPeripheral = 8'h01;
  localparam rst_act_t RstActEscalate   = 8'h02;

  // Bit positions in the ENEC/DISEC defining byte
  localparam int unsigned EnecIbiBit = 0;
  localparam int unsigned EnecCrrBit = 1;
  localparam int unsigned EnecHjBit  = 3;

endpackage

`default_nettype wire

//--- verilog/bus_monitor.sv
// Synchronizes SCL and SDA, flags bus conditions and detects the target reset pattern
`default_nettype none
`timescale 1ns/1ps

module bus_monitor #(
  parameter int unsigned MinResetEdges = 14
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic                       enable_i,
  output i3c_target_pkg::bus_event_t bus_o,
  output logic                       target_reset_o
);
  import i3c_target_pkg::*;

  localparam int unsigned CntW = $clog2(MinResetEdges + 1);
  localparam logic [CntW-1:0] EdgeMax = CntW'(MinResetEdges);

  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  logic scl_q;
  logic sda_q;
  logic scl_rise;
  logic scl_fall;
  logic sda_rise;
  logic sda_fall;
  logic start_det;
  logic stop_det;
  logic in_frame;
  logic [CntW-1:0] edge_cnt;
  logic pattern_seen;
  logic sr_seen;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_i};
      sda_sync <= {sda_sync[0], sda_i};
      scl_q    <= scl_sync[1];
      sda_q    <= sda_sync[1];
    end
  end

  assign scl_rise  = scl_sync[1] & ~scl_q;
  assign scl_fall  = ~scl_sync[1] & scl_q;
  assign sda_rise  = sda_sync[1] & ~sda_q;
  assign sda_fall  = ~sda_sync[1] & sda_q;
  // SDA may only move while SCL stays high for START and STOP
  assign start_det = enable_i & sda_fall & scl_sync[1] & scl_q;
  assign stop_det  = enable_i & sda_rise & scl_sync[1] & scl_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_o     <= '0;
      bus_o.sda <= 1'b1;
      in_frame  <= 1'b0;
    end else begin
      bus_o.start    <= start_det & ~in_frame;
      bus_o.rstart   <= start_det & in_frame;
      bus_o.stop     <= stop_det;
      bus_o.scl_rise <= enable_i & scl_rise;
      bus_o.scl_fall <= enable_i & scl_fall;
      bus_o.sda      <= sda_sync[1];
      if (start_det) begin
        in_frame <= 1'b1;
      end else if (stop_det) begin
        in_frame <= 1'b0;
      end
    end
  end

  // Reset pattern: SDA toggles with SCL low, then SCL high, Sr and P
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt       <= '0;
      pattern_seen   <= 1'b0;
      sr_seen        <= 1'b0;
      target_reset_o <= 1'b0;
    end else begin
      target_reset_o <= 1'b0;
      if (!enable_i) begin
        edge_cnt     <= '0;
        pattern_seen <= 1'b0;
        sr_seen      <= 1'b0;
      end else if (scl_rise) begin
        pattern_seen <= (edge_cnt >= EdgeMax);
        sr_seen      <= 1'b0;
        edge_cnt     <= '0;
      end else if (!scl_sync[1]) begin
        if ((sda_rise || sda_fall) && edge_cnt < EdgeMax) begin
          edge_cnt <= edge_cnt + 1'b1;
        end
      end else if (pattern_seen && start_det) begin
        sr_seen <= 1'b1;
      end else if (sr_seen && stop_det) begin
        target_reset_o <= 1'b1;
        pattern_seen   <= 1'b0;
        sr_seen        <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/bus_rx_flow.sv
// Samples SDA on each SCL rise and strobes out every byte and every ninth bit
`default_nettype none
`timescale 1ns/1ps

module bus_rx_flow (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_event_t bus_i,
  output i3c_target_pkg::byte_t      byte_o,
  output logic                       byte_valid_o,
  output logic                       ninth_o,
  output logic                       ninth_valid_o
);
  import i3c_target_pkg::*;

  logic [3:0] bit_cnt;
  byte_t shift_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt       <= '0;
      byte_valid_o  <= 1'b0;
      ninth_valid_o <= 1'b0;
    end else begin
      byte_valid_o  <= bus_i.scl_rise && bit_cnt == 4'd7;
      ninth_valid_o <= bus_i.scl_rise && bit_cnt == 4'd8;
      if (bus_i.start || bus_i.rstart) begin
        bit_cnt <= '0;
      end else if (bus_i.scl_rise) begin
        bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
      end
    end
  end

  // Byte stays in place across the ninth bit
  always_ff @(posedge clk_i) begin
    if (bus_i.scl_rise) begin
      if (bit_cnt == 4'd8) begin
        ninth_o <= bus_i.sda;
      end else begin
        shift_q <= {shift_q[6:0], bus_i.sda};
      end
    end
  end

  assign byte_o = shift_q;

endmodule

`default_nettype wire

//--- verilog/target_fsm.sv
// SDR frame handling of the target: address match, ACK, T-bit check and byte routing
`default_nettype none
`timescale 1ns/1ps

module target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  i3c_target_pkg::addr_cfg_t  addr_cfg_i,
  input  i3c_target_pkg::bus_event_t bus_i,
  input  i3c_target_pkg::byte_t      byte_i,
  input  logic                       byte_valid_i,
  input  logic                       ninth_i,
  input  logic                       ninth_valid_i,
  output logic                       sda_o,
  output i3c_target_pkg::ccc_beat_t  ccc_beat_o,
  output logic                       ccc_beat_valid_o,
  output i3c_target_pkg::byte_t      wr_byte_o,
  output logic                       wr_parity_err_o,
  output logic                       wr_byte_valid_o,
  output logic                       wr_end_o
);
  import i3c_target_pkg::*;

  fsm_state_e state_q;
  byte_t data_q;
  logic is_bcast_q;
  addr_t rx_addr;
  logic rx_rnw;
  logic own_match;
  logic addr_match;
  logic parity_ok;
  logic frame_edge;

  assign rx_addr = byte_i[7:1];
  assign rx_rnw  = byte_i[0];

  // Static address answers only until a dynamic one is assigned
  assign own_match = (addr_cfg_i.dyn_valid && rx_addr == addr_cfg_i.dyn_addr) ||
                     (!addr_cfg_i.dyn_valid && addr_cfg_i.sta_valid &&
                      rx_addr == addr_cfg_i.sta_addr);
  assign addr_match = !rx_rnw && (own_match || rx_addr == BroadcastAddr);

  // T bit makes the ones count odd
  assign parity_ok  = ^{data_q, ninth_i};
  assign frame_edge = bus_i.start | bus_i.rstart | bus_i.stop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= Idle;
      sda_o            <= 1'b1;
      ccc_beat_valid_o <= 1'b0;
      wr_byte_valid_o  <= 1'b0;
      wr_end_o         <= 1'b0;
    end else begin
      ccc_beat_valid_o <= 1'b0;
      wr_byte_valid_o  <= 1'b0;
      wr_end_o         <= 1'b0;
      if (!enable_i) begin
        state_q <= Idle;
        sda_o   <= 1'b1;
      end else if (frame_edge) begin
        wr_end_o <= (state_q == WriteData);
        sda_o    <= 1'b1;
        state_q  <= bus_i.stop ? Idle : Address;
      end else begin
        unique case (state_q)
          Address: begin
            if (byte_valid_i) begin
              state_q <= addr_match ? AckAddress : Ignore;
            end
          end
          AckAddress: begin
            // First SCL fall pulls SDA low, the next one ends the ACK
            if (bus_i.scl_fall) begin
              if (sda_o) begin
                sda_o <= 1'b0;
              end else begin
                sda_o   <= 1'b1;
                state_q <= is_bcast_q ? CccCode : WriteData;
              end
            end
          end
          CccCode: begin
            if (ninth_valid_i && parity_ok) begin
              ccc_beat_valid_o <= 1'b1;
              state_q          <= CccData;
            end
          end
          CccData: begin
            if (ninth_valid_i && parity_ok) begin
              ccc_beat_valid_o <= 1'b1;
            end
          end
          WriteData: begin
            if (ninth_valid_i) begin
              wr_byte_valid_o <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      data_q <= byte_i;
    end
    if (state_q == Address && byte_valid_i) begin
      is_bcast_q <= (rx_addr == BroadcastAddr);
    end
    if (ninth_valid_i) begin
      ccc_beat_o.is_code <= (state_q == CccCode);
      ccc_beat_o.value   <= data_q;
      wr_byte_o          <= data_q;
      wr_parity_err_o    <= !parity_ok;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ccc_decoder.sv
// Executes the broadcast CCCs ENEC, DISEC, SETMWL and RSTACT and keeps their state
`default_nettype none
`timescale 1ns/1ps

module ccc_decoder #(
  parameter i3c_target_pkg::count_t MwlResetValue = 16'h0100
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  i3c_target_pkg::ccc_beat_t ccc_beat_i,
  input  logic                      ccc_beat_valid_i,
  output i3c_target_pkg::event_en_t event_en_o,
  output i3c_target_pkg::count_t    mwl_o,
  output logic                      set_mwl_o,
  output i3c_target_pkg::rst_act_t  rst_act_o,
  output logic                      rst_act_valid_o
);
  import i3c_target_pkg::*;

  byte_t code_q;
  logic [1:0] data_cnt_q;
  byte_t mwl_msb_q;
  event_en_t en_sel;
  logic data_beat;

  assign en_sel.ibi = ccc_beat_i.value[EnecIbiBit];
  assign en_sel.crr = ccc_beat_i.value[EnecCrrBit];
  assign en_sel.hj  = ccc_beat_i.value[EnecHjBit];
  assign data_beat  = ccc_beat_valid_i && !ccc_beat_i.is_code;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q          <= '0;
      data_cnt_q      <= '1;
      event_en_o      <= '1;
      mwl_o           <= MwlResetValue;
      set_mwl_o       <= 1'b0;
      rst_act_valid_o <= 1'b0;
    end else begin
      set_mwl_o       <= 1'b0;
      rst_act_valid_o <= 1'b0;
      if (ccc_beat_valid_i && ccc_beat_i.is_code) begin
        code_q     <= ccc_beat_i.value;
        data_cnt_q <= '0;
      end else if (data_beat) begin
        if (data_cnt_q != 2'd3) begin
          data_cnt_q <= data_cnt_q + 2'd1;
        end
        unique case (code_q)
          CccEnec: begin
            if (data_cnt_q == 2'd0) begin
              event_en_o <= event_en_o | en_sel;
            end
          end
          CccDisec: begin
            if (data_cnt_q == 2'd0) begin
              event_en_o <= event_en_o & ~en_sel;
            end
          end
          CccSetmwl: begin
            // MSB came first
            if (data_cnt_q == 2'd1) begin
              mwl_o     <= {mwl_msb_q, ccc_beat_i.value};
              set_mwl_o <= 1'b1;
            end
          end
          CccRstact: begin
            rst_act_valid_o <= (data_cnt_q == 2'd0);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_beat && data_cnt_q == 2'd0) begin
      mwl_msb_q <= ccc_beat_i.value;
      rst_act_o <= ccc_beat_i.value;
    end
  end

endmodule

`default_nettype wire

//--- verilog/descriptor_rx.sv
// Forwards good private-write bytes and emits one RX descriptor per write
`default_nettype none
`timescale 1ns/1ps

module descriptor_rx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_target_pkg::byte_t    wr_byte_i,
  input  logic                     wr_parity_err_i,
  input  logic                     wr_byte_valid_i,
  input  logic                     wr_end_i,
  output i3c_target_pkg::byte_t    rx_data_o,
  output logic                     rx_data_valid_o,
  output i3c_target_pkg::rx_desc_t rx_desc_o,
  output logic                     rx_desc_valid_o
);
  import i3c_target_pkg::*;

  count_t count_q;
  logic err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q         <= '0;
      err_q           <= 1'b0;
      rx_data_valid_o <= 1'b0;
      rx_desc_valid_o <= 1'b0;
    end else begin
      rx_data_valid_o <= wr_byte_valid_i && !wr_parity_err_i;
      rx_desc_valid_o <= wr_end_i;
      if (wr_end_i) begin
        count_q <= '0;
        err_q   <= 1'b0;
      end else if (wr_byte_valid_i) begin
        // Bad bytes only mark the descriptor
        if (wr_parity_err_i) begin
          err_q <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_byte_valid_i) begin
      rx_data_o <= wr_byte_i;
    end
    if (wr_end_i) begin
      rx_desc_o.err        <= err_q;
      rx_desc_o.byte_count <= count_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reset_action.sv
// Turns RSTACT and target reset patterns into peripheral and escalated resets
`default_nettype none
`timescale 1ns/1ps

module reset_action (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_target_pkg::rst_act_t rst_act_i,
  input  logic                     rst_act_valid_i,
  input  logic                     target_reset_i,
  input  logic                     peripheral_reset_done_i,
  output logic                     peripheral_reset_o,
  output logic                     escalated_reset_o
);
  import i3c_target_pkg::*;

  rst_act_t armed_q;
  logic escalate_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q            <= RstActPeripheral;
      escalate_q         <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end
      if (rst_act_valid_i) begin
        armed_q    <= rst_act_i;
        escalate_q <= 1'b0;
      end else if (target_reset_i) begin
        // Pattern consumes the armed action
        armed_q <= RstActPeripheral;
        if (armed_q == RstActEscalate || escalate_q) begin
          escalated_reset_o <= 1'b1;
        end else begin
          peripheral_reset_o <= 1'b1;
          escalate_q         <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/i3c_target_top.sv
// Top level of the I3C SDR target, connecting the bus front end, FSM, CCC and RX paths
`default_nettype none
`timescale 1ns/1ps

module i3c_target_top #(
  parameter int unsigned            MinResetEdges = 14,
  parameter i3c_target_pkg::count_t MwlResetValue = 16'h0100
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      enable_i,
  input  logic                      scl_i,
  input  logic                      sda_i,
  input  i3c_target_pkg::addr_cfg_t addr_cfg_i,
  input  logic                      peripheral_reset_done_i,
  output logic                      sda_o,
  output i3c_target_pkg::byte_t     rx_data_o,
  output logic                      rx_data_valid_o,
  output i3c_target_pkg::rx_desc_t  rx_desc_o,
  output logic                      rx_desc_valid_o,
  output i3c_target_pkg::event_en_t event_en_o,
  output i3c_target_pkg::count_t    mwl_o,
  output logic                      set_mwl_o,
  output logic                      peripheral_reset_o,
  output logic                      escalated_reset_o
);
  import i3c_target_pkg::*;

  bus_event_t bus;
  logic target_reset;

  byte_t rx_byte;
  logic rx_byte_valid;
  logic rx_ninth;
  logic rx_ninth_valid;

  ccc_beat_t ccc_beat;
  logic ccc_beat_valid;

  byte_t wr_byte;
  logic wr_parity_err;
  logic wr_byte_valid;
  logic wr_end;

  rst_act_t rst_act;
  logic rst_act_valid;

  bus_monitor #(
    .MinResetEdges(MinResetEdges)
  ) bus_monitor_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .enable_i      (enable_i),
    .bus_o         (bus),
    .target_reset_o(target_reset)
  );

  bus_rx_flow bus_rx_flow_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_i        (bus),
    .byte_o       (rx_byte),
    .byte_valid_o (rx_byte_valid),
    .ninth_o      (rx_ninth),
    .ninth_valid_o(rx_ninth_valid)
  );

  target_fsm target_fsm_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_i        (enable_i),
    .addr_cfg_i      (addr_cfg_i),
    .bus_i           (bus),
    .byte_i          (rx_byte),
    .byte_valid_i    (rx_byte_valid),
    .ninth_i         (rx_ninth),
    .ninth_valid_i   (rx_ninth_valid),
    .sda_o           (sda_o),
    .ccc_beat_o      (ccc_beat),
    .ccc_beat_valid_o(ccc_beat_valid),
    .wr_byte_o       (wr_byte),
    .wr_parity_err_o (wr_parity_err),
    .wr_byte_valid_o (wr_byte_valid),
    .wr_end_o        (wr_end)
  );

  ccc_decoder #(
    .MwlResetValue(MwlResetValue)
  ) ccc_decoder_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ccc_beat_i      (ccc_beat),
    .ccc_beat_valid_i(ccc_beat_valid),
    .event_en_o      (event_en_o),
    .mwl_o           (mwl_o),
    .set_mwl_o       (set_mwl_o),
    .rst_act_o       (rst_act),
    .rst_act_valid_o (rst_act_valid)
  );

  descriptor_rx descriptor_rx_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_byte_i      (wr_byte),
    .wr_parity_err_i(wr_parity_err),
    .wr_byte_valid_i(wr_byte_valid),
    .wr_end_i       (wr_end),
    .rx_data_o      (rx_data_o),
    .rx_data_valid_o(rx_data_valid_o),
    .rx_desc_o      (rx_desc_o),
    .rx_desc_valid_o(rx_desc_valid_o)
  );

  reset_action reset_action_inst (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .rst_act_i              (rst_act),
    .rst_act_valid_i        (rst_act_valid),
    .target_reset_i         (target_reset),
    .peripheral_reset_done_i(peripheral_reset_done_i),
    .peripheral_reset_o     (peripheral_reset_o),
    .escalated_reset_o      (escalated_reset_o)
  );

endmodule

`default_nettype wire

//--- test/i3c_target_asserts.sv
// Concurrent protocol checks on the I3C target top level, attached with bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module i3c_target_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic sda_o,
  input logic set_mwl_o,
  input logic rx_data_valid_o,
  input logic rx_desc_valid_o,
  input logic peripheral_reset_o,
  input logic escalated_reset_o,
  input logic peripheral_reset_done_i
);

  // Failure tallies per property
  int reset_idle_fails = 0;
  int escalated_fell_fails = 0;
  int set_mwl_long_fails = 0;
  int peripheral_early_fails = 0;

  reset_outputs_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (sda_o && !set_mwl_o && !rx_data_valid_o && !rx_desc_valid_o &&
                       !peripheral_reset_o && !escalated_reset_o))
  else begin
    $error("outputs active right after reset");
    reset_idle_fails++;
  end

  // Only rst_ni may clear an escalated reset
  escalated_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$fell(escalated_reset_o))
  else begin
    $error("escalated reset dropped without rst_ni");
    escalated_fell_fails++;
  end

  set_mwl_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mwl_o |=> !set_mwl_o)
  else begin
    $error("set_mwl_o high for more than one cycle");
    set_mwl_long_fails++;
  end

  peripheral_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(peripheral_reset_o) |-> $past(peripheral_reset_done_i))
  else begin
    $error("peripheral reset released without done");
    peripheral_early_fails++;
  end

endmodule

`default_nettype wire

//--- test/tb_i3c_target.sv
// Testbench for the I3C SDR target, drives an open-drain bus and checks writes, CCCs and resets
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_target;
  import i3c_target_pkg::*;

  localparam int unsigned ResetEdges = 14;
  localparam count_t MwlReset = 16'h0100;
  localparam addr_t StaAddr = 7'h50;
  localparam addr_t DynAddr = 7'h2B;
  localparam addr_t OtherAddr = 7'h15;
  localparam int Timeout = 2000;

  logic clk_i;
  logic rst_ni;
  logic enable;
  logic scl;
  logic sda_drv;
  logic sda_line;
  logic prst_done;
  addr_cfg_t addr_cfg;
  logic sda_o;
  byte_t rx_data;
  logic rx_data_valid;
  rx_desc_t rx_desc;
  logic rx_desc_valid;
  event_en_t event_en;
  count_t mwl;
  logic set_mwl;
  logic peripheral_reset;
  logic escalated_reset;

  byte_t rx_seen[$];
  rx_desc_t desc_seen[$];
  int mwl_pulses = 0;
  int sda_low_cycles = 0;

  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0 = 0;
  int assert_fails = 0;
  string test_name;

  // Open-drain wire, either side can pull low
  assign sda_line = sda_drv & sda_o;

  i3c_target_top #(
    .MinResetEdges(ResetEdges),
    .MwlResetValue(MwlReset)
  ) i3c_target_top_inst (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .enable_i               (enable),
    .scl_i                  (scl),
    .sda_i                  (sda_line),
    .addr_cfg_i             (addr_cfg),
    .peripheral_reset_done_i(prst_done),
    .sda_o                  (sda_o),
    .rx_data_o              (rx_data),
    .rx_data_valid_o        (rx_data_valid),
    .rx_desc_o              (rx_desc),
    .rx_desc_valid_o        (rx_desc_valid),
    .event_en_o             (event_en),
    .mwl_o                  (mwl),
    .set_mwl_o              (set_mwl),
    .peripheral_reset_o     (peripheral_reset),
    .escalated_reset_o      (escalated_reset)
  );

  bind i3c_target_top i3c_target_asserts i3c_target_asserts_inst (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .sda_o                  (sda_o),
    .set_mwl_o              (set_mwl_o),
    .rx_data_valid_o        (rx_data_valid_o),
    .rx_desc_valid_o        (rx_desc_valid_o),
    .peripheral_reset_o     (peripheral_reset_o),
    .escalated_reset_o      (escalated_reset_o),
    .peripheral_reset_done_i(peripheral_reset_done_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Strobe collector
  always @(posedge clk_i) begin
    if (rx_data_valid) rx_seen.push_back(rx_data);
    if (rx_desc_valid) desc_seen.push_back(rx_desc);
    if (set_mwl) mwl_pulses++;
    if (!sda_o) sda_low_cycles++;
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic check_eq(input string what, input logic [31:0] expv, input logic [31:0] actv);
    assert (expv === actv) else begin
      $display("FAIL %s: %s expected 0x%0h actual 0x%0h", test_name, what, expv, actv);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt != test_err0) tests_failed++;
    $display("%-16s %s", test_name, (err_cnt == test_err0) ? "passed" : "failed");
  endtask

  // Each SCL half period is 8 clocks, SDA moves mid low phase
  task automatic send_bit(input logic b, output logic seen);
    tick(4);
    sda_drv = b;
    tick(4);
    scl = 1'b1;
    tick(4);
    seen = sda_line;
    tick(4);
    scl = 1'b0;
  endtask

  task automatic bus_start();
    sda_drv = 1'b0;
    tick(8);
    scl = 1'b0;
  endtask

  task automatic bus_stop();
    tick(4);
    sda_drv = 1'b0;
    tick(4);
    scl = 1'b1;
    tick(8);
    sda_drv = 1'b1;
    tick(8);
  endtask

  task automatic send_header(input addr_t a, output logic acked);
    logic [7:0] hdr;
    logic seen;
    hdr = {a, 1'b0};
    for (int i = 7; i >= 0; i--) send_bit(hdr[i], seen);
    send_bit(1'b1, seen);
    acked = !seen;
  endtask

  // T bit gives an odd count of ones, bad_t flips it
  task automatic send_data(input byte_t b, input logic bad_t);
    logic seen;
    for (int i = 7; i >= 0; i--) send_bit(b[i], seen);
    send_bit(~(^b) ^ bad_t, seen);
  endtask

  task automatic send_pattern();
    tick(4);
    scl = 1'b0;
    repeat (ResetEdges) begin
      tick(4);
      sda_drv = ~sda_drv;
    end
    tick(4);
    scl = 1'b1;
    tick(8);
    sda_drv = 1'b0;
    tick(8);
    sda_drv = 1'b1;
    tick(8);
  endtask

  task automatic wait_desc(input int n);
    int cnt;
    cnt = 0;
    while (desc_seen.size() < n && cnt < Timeout) begin
      tick(1);
      cnt++;
    end
    if (desc_seen.size() < n) begin
      $display("%s: no RX descriptor arrived within %0d cycles", test_name, Timeout);
      err_cnt++;
    end
  endtask

  task automatic wait_reset_out(input logic esc, input logic level);
    int cnt;
    cnt = 0;
    while (((esc ? escalated_reset : peripheral_reset) !== level) && cnt < Timeout) begin
      tick(1);
      cnt++;
    end
    if ((esc ? escalated_reset : peripheral_reset) !== level) begin
      $display("%s: reset output did not reach %0b within %0d cycles", test_name, level, Timeout);
      err_cnt++;
    end
  endtask

  task automatic run_write(input addr_t a, input int n, input int bad_idx);
    byte_t b;
    byte_t exp_q[$];
    logic acked;
    int rx0;
    int d0;
    rx0 = rx_seen.size();
    d0 = desc_seen.size();
    bus_start();
    send_header(a, acked);
    check_eq("address ack", 1, acked);
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      send_data(b, i == bad_idx);
      if (i != bad_idx) exp_q.push_back(b);
    end
    bus_stop();
    wait_desc(d0 + 1);
    check_eq("data count", exp_q.size(), rx_seen.size() - rx0);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (rx0 + i < rx_seen.size()) check_eq("data byte", exp_q[i], rx_seen[rx0 + i]);
    end
    if (desc_seen.size() > d0) begin
      check_eq("descriptor count", exp_q.size(), desc_seen[d0].byte_count);
      check_eq("descriptor err", (bad_idx >= 0) ? 1 : 0, desc_seen[d0].err);
    end
  endtask

  task automatic send_ccc(input byte_t code, input byte_t d0, input byte_t d1, input int ndata);
    logic acked;
    bus_start();
    send_header(BroadcastAddr, acked);
    check_eq("broadcast ack", 1, acked);
    send_data(code, 1'b0);
    send_data(d0, 1'b0);
    if (ndata > 1) send_data(d1, 1'b0);
    bus_stop();
  endtask

  initial begin
    byte_t d;
    byte_t msb;
    byte_t lsb;
    logic [2:0] exp_en;
    logic acked;
    int rx0;
    int d0;
    int low0;
    int p0;
    void'($urandom(97845));
    rst_ni = 1'b0;
    enable = 1'b1;
    scl = 1'b1;
    sda_drv = 1'b1;
    prst_done = 1'b0;
    addr_cfg.sta_addr = StaAddr;
    addr_cfg.sta_valid = 1'b1;
    addr_cfg.dyn_addr = DynAddr;
    addr_cfg.dyn_valid = 1'b1;
    tick(8);
    rst_ni = 1'b1;
    tick(4);

    begin_test("private_write");
    run_write(DynAddr, 3, -1);
    addr_cfg.dyn_valid = 1'b0;
    run_write(StaAddr, 3, -1);
    addr_cfg.dyn_valid = 1'b1;
    end_test();

    begin_test("foreign_address");
    rx0 = rx_seen.size();
    d0 = desc_seen.size();
    low0 = sda_low_cycles;
    bus_start();
    send_header(OtherAddr, acked);
    send_data(8'($urandom), 1'b0);
    send_data(8'($urandom), 1'b0);
    bus_stop();
    tick(20);
    check_eq("address ack", 0, acked);
    check_eq("sda low cycles", 0, sda_low_cycles - low0);
    check_eq("data count", 0, rx_seen.size() - rx0);
    check_eq("descriptor count", 0, desc_seen.size() - d0);
    end_test();

    begin_test("parity_error");
    run_write(DynAddr, 4, 1);
    end_test();

    begin_test("ccc_commands");
    exp_en = 3'b111;
    check_eq("enables after reset", exp_en, event_en);
    check_eq("mwl after reset", MwlReset, mwl);
    d = 8'($urandom);
    send_ccc(CccDisec, d, 8'h00, 1);
    exp_en = exp_en & ~{d[EnecIbiBit], d[EnecCrrBit], d[EnecHjBit]};
    check_eq("enables after DISEC", exp_en, event_en);
    send_ccc(CccEnec, d, 8'h00, 1);
    exp_en = exp_en | {d[EnecIbiBit], d[EnecCrrBit], d[EnecHjBit]};
    check_eq("enables after ENEC", exp_en, event_en);
    p0 = mwl_pulses;
    msb = 8'($urandom);
    lsb = 8'($urandom);
    send_ccc(CccSetmwl, msb, lsb, 2);
    check_eq("mwl", {msb, lsb}, mwl);
    check_eq("set_mwl pulses", 1, mwl_pulses - p0);
    end_test();

    begin_test("reset_patterns");
    send_pattern();
    wait_reset_out(1'b0, 1'b1);
    tick(20);
    check_eq("peripheral reset held", 1, peripheral_reset);
    prst_done = 1'b1;
    tick(1);
    prst_done = 1'b0;
    wait_reset_out(1'b0, 1'b0);
    send_pattern();
    wait_reset_out(1'b1, 1'b1);
    check_eq("peripheral reset on escalation", 0, peripheral_reset);
    rst_ni = 1'b0;
    tick(8);
    rst_ni = 1'b1;
    tick(4);
    check_eq("escalated after rst_ni", 0, escalated_reset);
    send_ccc(CccRstact, RstActEscalate, 8'h00, 1);
    send_pattern();
    wait_reset_out(1'b1, 1'b1);
    check_eq("peripheral reset with RSTACT", 0, peripheral_reset);
    end_test();

    assert_fails = i3c_target_top_inst.i3c_target_asserts_inst.reset_idle_fails +
                   i3c_target_top_inst.i3c_target_asserts_inst.escalated_fell_fails +
                   i3c_target_top_inst.i3c_target_asserts_inst.set_mwl_long_fails +
                   i3c_target_top_inst.i3c_target_asserts_inst.peripheral_early_fails;
    if (assert_fails != 0) begin
      $display("concurrent assertions failed %0d times", assert_fails);
    end
    $display("tests %0d, passed %0d, failed %0d, check errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, err_cnt + assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/i3c_target_pkg.sv
verilog/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/target_fsm.sv
verilog/ccc_decoder.sv
verilog/descriptor_rx.sv
verilog/reset_action.sv
verilog/i3c_target_top.sv
test/i3c_target_asserts.sv
test/tb_i3c_target.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_target \
  -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_i3c_target +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
